/* hdl/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// address split is tag | index | word | byte
`define CACHE_ADDR_LEN     16
`define CACHE_TAG_LEN      7
`define CACHE_INDEX_LEN    4
`define CACHE_OFFSET_LEN   5

// line layout
`define CACHE_WORD_LEN     64
`define CACHE_WORD_SEL_LEN 2
`define CACHE_BEATS        4

`define CACHE_WAYS         2
`define CACHE_SETS         16

`endif

/* hdl/cache_pkg.sv */
`default_nettype none
`include "cache_consts.svh"

package cache_pkg;

	// field view of an address, high bits first
	typedef struct packed {
		logic [`CACHE_TAG_LEN-1:0]                        tag;
		logic [`CACHE_INDEX_LEN-1:0]                      index;
		logic [`CACHE_WORD_SEL_LEN-1:0]                   word;
		logic [`CACHE_OFFSET_LEN-`CACHE_WORD_SEL_LEN-1:0] byte_sel;
	} cache_addr_fields_t;

	typedef union packed {
		logic [`CACHE_ADDR_LEN-1:0] flat;
		cache_addr_fields_t         f;
	} cache_addr_t;

	typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, RESPOND} ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/cache_fill_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

interface cache_fill_if;

	logic                           refill;
	logic                           beat_en;
	logic                           last;
	logic [`CACHE_INDEX_LEN-1:0]    fill_index;
	logic [`CACHE_TAG_LEN-1:0]      fill_tag;
	logic                           fill_way;
	logic [`CACHE_WORD_SEL_LEN-1:0] fill_beat;

	modport ctrl (output refill, beat_en, last, fill_index, fill_tag);
	modport counter (input refill, beat_en, output fill_beat);
	// victim way is owned by the tag side
	modport tags (input last, fill_index, fill_tag, output fill_way);
	modport data (input beat_en, last, fill_index, fill_way, fill_beat);

endinterface

`default_nettype wire

/* hdl/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module cache_ctrl
	import cache_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        req_valid,
	input  cache_addr_t req_addr,
	input  logic        hit,
	input  logic        raxi_dvalid,
	input  logic        raxi_dlast,
	output logic        addr_ok,
	output logic        data_ok,
	output logic        accept,
	output cache_addr_t req_q,
	output logic        raxi_valid,
	output cache_addr_t raxi_addr,
	cache_fill_if.ctrl  fill
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic        lookup_hit;
	logic        beat_seen;

	// hit is only meaningful in the cycle after accept
	assign lookup_hit = (state == LOOKUP) && hit;

	assign addr_ok = (state == IDLE) || lookup_hit;
	assign accept = req_valid && addr_ok;
	assign data_ok = lookup_hit || (state == RESPOND);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (accept) begin
					state_nxt = LOOKUP;
				end
			end
			LOOKUP: begin
				if (!hit) begin
					state_nxt = REFILL;
				end else if (!accept) begin
					state_nxt = IDLE;
				end
			end
			REFILL: begin
				if (fill.last) begin
					state_nxt = RESPOND;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// request buffer, held through a miss
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req_addr;
		end
	end

	// request stays up until memory starts answering
	always_ff @(posedge clk) begin
		if (rst || !fill.refill) begin
			beat_seen <= 1'b0;
		end else if (fill.beat_en) begin
			beat_seen <= 1'b1;
		end
	end

	assign raxi_valid = fill.refill && !beat_seen;
	assign raxi_addr.flat = {req_q.f.tag, req_q.f.index, {`CACHE_OFFSET_LEN{1'b0}}};

	assign fill.refill = (state == REFILL);
	assign fill.beat_en = fill.refill && raxi_dvalid;
	assign fill.last = fill.beat_en && raxi_dlast;
	assign fill.fill_index = req_q.f.index;
	assign fill.fill_tag = req_q.f.tag;

endmodule

`default_nettype wire

/* hdl/refill_counter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module refill_counter (
	input  logic          clk,
	input  logic          rst,
	cache_fill_if.counter fill
);

	logic [`CACHE_WORD_SEL_LEN-1:0] beat_cnt;

	// number of beats already taken in this refill
	always_ff @(posedge clk) begin
		if (rst || !fill.refill) begin
			beat_cnt <= '0;
		end else if (fill.beat_en) begin
			// wraps to zero after the last word of the line
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	assign fill.fill_beat = beat_cnt;

endmodule

`default_nettype wire

/* hdl/tag_store.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module tag_store
	import cache_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        accept,
	input  cache_addr_t req_addr,
	input  cache_addr_t req_q,
	output logic        hit,
	output logic        hit_way,
	cache_fill_if.tags  fill
);

	logic [`CACHE_TAG_LEN-1:0]                    tag_mem [`CACHE_WAYS][`CACHE_SETS];
	logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0]      valid_bits;
	logic [`CACHE_SETS-1:0]                       victim;
	logic [`CACHE_TAG_LEN-1:0]                    tag_rd [`CACHE_WAYS];
	logic [`CACHE_WAYS-1:0]                       valid_rd;
	logic [`CACHE_WAYS-1:0]                       way_hit;

	// synchronous lookup read, both ways at once
	always_ff @(posedge clk) begin
		if (accept) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				tag_rd[w] <= tag_mem[w][req_addr.f.index];
				valid_rd[w] <= valid_bits[w][req_addr.f.index];
			end
		end
	end

	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			way_hit[w] = valid_rd[w] && (tag_rd[w] == req_q.f.tag);
		end
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1];

	// fill goes to the way the victim bit points at
	assign fill.fill_way = victim[fill.fill_index];

	// tag written once the whole line is in
	always_ff @(posedge clk) begin
		if (fill.last) begin
			tag_mem[fill.fill_way][fill.fill_index] <= fill.fill_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
			victim <= '0;
		end else if (fill.last) begin
			valid_bits[fill.fill_way][fill.fill_index] <= 1'b1;
			// next miss in this set replaces the other way
			victim[fill.fill_index] <= ~victim[fill.fill_index];
		end
	end

endmodule

`default_nettype wire

/* hdl/data_store.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module data_store
	import cache_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       accept,
	input  cache_addr_t                req_addr,
	input  cache_addr_t                req_q,
	input  logic                       hit_way,
	input  logic [`CACHE_WORD_LEN-1:0] raxi_data,
	output logic [`CACHE_WORD_LEN-1:0] rdata,
	cache_fill_if.data                 fill
);

	logic [`CACHE_WORD_LEN-1:0] data_mem [`CACHE_WAYS][`CACHE_SETS][`CACHE_BEATS];
	logic [`CACHE_WORD_LEN-1:0] rd_word [`CACHE_WAYS];
	logic [`CACHE_WORD_LEN-1:0] miss_word;
	logic                       respond;

	// addressed word of both ways, picked later by hit_way
	always_ff @(posedge clk) begin
		if (accept) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				rd_word[w] <= data_mem[w][req_addr.f.index][req_addr.f.word];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill.beat_en) begin
			data_mem[fill.fill_way][fill.fill_index][fill.fill_beat] <= raxi_data;
		end
	end

	// keep the word the CPU asked for as it goes by
	always_ff @(posedge clk) begin
		if (fill.beat_en && (fill.fill_beat == req_q.f.word)) begin
			miss_word <= raxi_data;
		end
	end

	// one cycle after the last beat, matches RESPOND
	always_ff @(posedge clk) begin
		if (rst) begin
			respond <= 1'b0;
		end else begin
			respond <= fill.last;
		end
	end

	assign rdata = respond ? miss_word : rd_word[hit_way];

endmodule

`default_nettype wire

/* hdl/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_consts.svh"

module icache_top
	import cache_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       req_valid,
	input  logic [`CACHE_ADDR_LEN-1:0] req_addr,
	output logic                       addr_ok,
	output logic                       data_ok,
	output logic [`CACHE_WORD_LEN-1:0] rdata,
	output logic                       raxi_valid,
	output logic [`CACHE_ADDR_LEN-1:0] raxi_addr,
	input  logic                       raxi_dvalid,
	input  logic                       raxi_dlast,
	input  logic [`CACHE_WORD_LEN-1:0] raxi_data
);

	logic        accept;
	cache_addr_t req_q;
	logic        hit;
	logic        hit_way;

	// refill beat traffic
	cache_fill_if fill_bus ();

	cache_ctrl ctrl_i (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.req_addr    (req_addr),
		.hit         (hit),
		.raxi_dvalid (raxi_dvalid),
		.raxi_dlast  (raxi_dlast),
		.addr_ok     (addr_ok),
		.data_ok     (data_ok),
		.accept      (accept),
		.req_q       (req_q),
		.raxi_valid  (raxi_valid),
		.raxi_addr   (raxi_addr),
		.fill        (fill_bus.ctrl)
	);

	refill_counter counter_i (
		.clk  (clk),
		.rst  (rst),
		.fill (fill_bus.counter)
	);

	tag_store tags_i (
		.clk      (clk),
		.rst      (rst),
		.accept   (accept),
		.req_addr (req_addr),
		.req_q    (req_q),
		.hit      (hit),
		.hit_way  (hit_way),
		.fill     (fill_bus.tags)
	);

	data_store data_i (
		.clk       (clk),
		.rst       (rst),
		.accept    (accept),
		.req_addr  (req_addr),
		.req_q     (req_q),
		.hit_way   (hit_way),
		.raxi_data (raxi_data),
		.rdata     (rdata),
		.fill      (fill_bus.data)
	);

endmodule

`default_nettype wire

/* tb/icache_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_sva (
	input logic        clk,
	input logic        rst,
	input logic        addr_ok,
	input logic        data_ok,
	input logic        raxi_valid,
	input logic [15:0] raxi_addr,
	input logic        raxi_dvalid,
	input logic        raxi_dlast
);

	// a pending refill blocks new requests
	no_accept_in_refill: assert property (
		@(posedge clk) disable iff (rst) !(raxi_valid && addr_ok)
	) else $error("raxi_valid and addr_ok high together");

	// answer comes right after the last beat
	respond_after_last: assert property (
		@(posedge clk) disable iff (rst) (raxi_dvalid && raxi_dlast && !addr_ok) |=> data_ok
	) else $error("no data_ok after the last refill beat");

	refill_addr_stable: assert property (
		@(posedge clk) disable iff (rst) (raxi_valid && $past(raxi_valid)) |-> $stable(raxi_addr)
	) else $error("raxi_addr changed while raxi_valid was high");

endmodule

`default_nettype wire

/* tb/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

	localparam int TIMEOUT = 100;
	localparam int N_TABLE = 8;
	localparam int N_BURST = 4;

	// address, expected hit
	localparam logic [16:0] STIM [N_TABLE] = '{
		{16'h1238, 1'b0},
		{16'h1238, 1'b1},
		{16'h1220, 1'b1},
		{16'h3420, 1'b0},
		{16'h5628, 1'b0},
		// third tag in set 1 pushed the first one out
		{16'h1238, 1'b0},
		{16'h5630, 1'b1},
		{16'h0000, 1'b0}
	};
	localparam logic [15:0] BURST_ADDR [N_BURST] = '{16'h1220, 16'h5638, 16'h0018, 16'h1230};

	logic        clk;
	logic        rst;
	logic        req_valid;
	logic [15:0] req_addr;
	logic        addr_ok;
	logic        data_ok;
	logic [63:0] rdata;
	logic        raxi_valid;
	logic [15:0] raxi_addr;
	logic        raxi_dvalid;
	logic        raxi_dlast;
	logic [63:0] raxi_data;

	int          errors = 0;
	int          timeouts = 0;
	int          refill_count = 0;
	int          model_misses = 0;
	int          seed = 32'h78c95377;
	logic [6:0]  model_tag [16][2];
	logic [1:0]  model_valid [16];
	logic        model_victim [16];

	icache_top dut_i (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.req_addr    (req_addr),
		.addr_ok     (addr_ok),
		.data_ok     (data_ok),
		.rdata       (rdata),
		.raxi_valid  (raxi_valid),
		.raxi_addr   (raxi_addr),
		.raxi_dvalid (raxi_dvalid),
		.raxi_dlast  (raxi_dlast),
		.raxi_data   (raxi_data)
	);

	bind icache_top icache_sva sva_i (
		.clk         (clk),
		.rst         (rst),
		.addr_ok     (addr_ok),
		.data_ok     (data_ok),
		.raxi_valid  (raxi_valid),
		.raxi_addr   (raxi_addr),
		.raxi_dvalid (raxi_dvalid),
		.raxi_dlast  (raxi_dlast)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// memory word from line address, beat number and a fixed pattern
	function automatic logic [63:0] beat_word(input logic [15:0] line, input logic [1:0] beat);
		return {line, 14'd0, beat, 32'h5a5a0000};
	endfunction

	task automatic log_error(input string msg);
		$display("Fail %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic log_timeout(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		timeouts++;
	endtask

	// two ways per set with the fill at the victim way, which then flips
	task automatic model_access(input logic [15:0] addr, output logic hit);
		logic [3:0] set;
		logic [6:0] tag;
		set = addr[8:5];
		tag = addr[15:9];
		hit = (model_valid[set][0] && model_tag[set][0] == tag)
			|| (model_valid[set][1] && model_tag[set][1] == tag);
		if (!hit) begin
			model_tag[set][model_victim[set]] = tag;
			model_valid[set][model_victim[set]] = 1'b1;
			model_victim[set] = !model_victim[set];
			model_misses++;
		end
	endtask

	// four back-to-back beats after 3 cycles of latency
	initial begin : mem_model
		logic [15:0] line;
		raxi_dvalid = 1'b0;
		raxi_dlast = 1'b0;
		raxi_data = '0;
		forever begin
			@(negedge clk);
			if (!rst && raxi_valid) begin
				line = raxi_addr;
				refill_count++;
				repeat (3) @(posedge clk);
				#2;
				for (int b = 0; b < 4; b++) begin
					if (b > 0) begin
						@(posedge clk);
						#2;
					end
					raxi_dvalid = 1'b1;
					raxi_dlast = (b == 3);
					raxi_data = beat_word(line, b[1:0]);
				end
				@(posedge clk);
				#2;
				raxi_dvalid = 1'b0;
				raxi_dlast = 1'b0;
			end
		end
	end

	task automatic do_read(input logic [15:0] addr, input logic exp_hit);
		int          waited;
		int          lat;
		logic        saw_req;
		logic        last_prev;
		logic [15:0] seen_addr;
		waited = 0;
		saw_req = 1'b0;
		last_prev = 1'b0;
		seen_addr = '0;
		req_valid = 1'b1;
		req_addr = addr;
		@(negedge clk);
		while (!addr_ok && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!addr_ok) log_timeout("addr_ok");
		@(posedge clk);
		#2;
		req_valid = 1'b0;
		@(negedge clk);
		lat = 1;
		while (!data_ok && lat < TIMEOUT) begin
			if (raxi_valid) begin
				saw_req = 1'b1;
				seen_addr = raxi_addr;
			end
			last_prev = raxi_dvalid && raxi_dlast;
			@(negedge clk);
			lat++;
		end
		// no refill request may come with the answer either
		if (raxi_valid) begin
			saw_req = 1'b1;
		end
		if (!data_ok) begin
			log_timeout("data_ok");
		end else begin
			assert (((lat == 1) && !saw_req) == exp_hit)
			else log_error($sformatf("%h hit %0b expected, latency %0d", addr, exp_hit, lat));
			if (!exp_hit) begin
				assert (saw_req && seen_addr == {addr[15:5], 5'b0})
				else log_error($sformatf("refill address %h for %h", seen_addr, addr));
				assert (last_prev) else log_error("data_ok not right after the last beat");
			end
			assert (rdata == beat_word({addr[15:5], 5'b0}, addr[4:3]))
			else log_error($sformatf("rdata %h for address %h", rdata, addr));
		end
		@(posedge clk);
		#2;
	endtask

	// request held high so a hit is answered every cycle
	task automatic hit_burst();
		int   n_acc;
		int   n_resp;
		int   cycles;
		logic took;
		n_acc = 0;
		n_resp = 0;
		cycles = 0;
		req_valid = 1'b1;
		req_addr = BURST_ADDR[0];
		while (n_resp < N_BURST && cycles < TIMEOUT) begin
			@(negedge clk);
			took = req_valid && addr_ok;
			assert (data_ok || n_resp == 0) else log_error("gap between back-to-back hits");
			assert (!raxi_valid) else log_error("refill during back-to-back hits");
			if (data_ok) begin
				assert (rdata == beat_word({BURST_ADDR[n_resp][15:5], 5'b0},
					BURST_ADDR[n_resp][4:3]))
				else log_error($sformatf("burst rdata %h at entry %0d", rdata, n_resp));
				n_resp++;
			end
			@(posedge clk);
			#2;
			if (took) begin
				n_acc++;
				if (n_acc < N_BURST) begin
					req_addr = BURST_ADDR[n_acc];
				end else begin
					req_valid = 1'b0;
				end
			end
			cycles++;
		end
		req_valid = 1'b0;
		if (n_resp < N_BURST) log_timeout("back-to-back data_ok");
	endtask

	initial begin
		logic        exp_hit;
		logic [31:0] r;
		logic [15:0] addr;
		int          refills_before;
		int          misses_before;
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		for (int s = 0; s < 16; s++) begin
			model_valid[s] = 2'b00;
			model_victim[s] = 1'b0;
		end
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		@(negedge clk);
		assert (addr_ok && !data_ok && !raxi_valid)
		else log_error("handshake outputs wrong after reset");
		@(posedge clk);
		#2;
		for (int i = 0; i < N_TABLE; i++) begin
			model_access(STIM[i][16:1], exp_hit);
			do_read(STIM[i][16:1], STIM[i][0]);
		end
		hit_burst();
		// four tags over sets 2 and 3
		refills_before = refill_count;
		misses_before = model_misses;
		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			addr = {5'b10000, r[1:0], 3'b001, r[2], r[4:3], r[7:5]};
			model_access(addr, exp_hit);
			do_read(addr, exp_hit);
		end
		assert (refill_count - refills_before == model_misses - misses_before)
		else log_error($sformatf("%0d refills, expected %0d",
			refill_count - refills_before, model_misses - misses_before));
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* icache_top.f */
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_fill_if.sv
hdl/cache_ctrl.sv
hdl/refill_counter.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/icache_top.sv
tb/icache_sva.sv
tb/icache_tb.sv

/* run.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it and judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module icache_tb -f icache_top.f \
	&& ./obj_dir/Vicache_tb > sim.log 2>&1 \
	|| echo "simulation did not complete" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0
